// File: source/rv_id_defs.svh
`ifndef RV_ID_DEFS_SVH
`define RV_ID_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Register file address width
`define RV_REG_AW 5

// addi x0, x0, 0
`define RV_NOP_INST 32'h0000_0013

`define RV_RESET_PC 32'h0000_0000

`endif

// File: source/rv_id_pkg.sv
package rv_id_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [5:0] {
        ALU_NOP,
        LB, LH, LW, LBU, LHU,                // Loads
        SB, SH, SW,                          // Stores
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND,
        ADDI, SLTI, SLTIU, XORI, ORI,
        ANDI, SLLI, SRLI, SRAI,
        LUI, AUIPC, JUMP, BRANCH
    } alu_op_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_JALR
    } jump_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } branch_op_e;

endpackage

// File: source/if_id_reg.sv
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module if_id_reg (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] inst_i,
    input  logic                inst_valid_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic [`RV_XLEN-1:0] inst_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o   <= `RV_RESET_PC;
            inst_o <= `RV_NOP_INST;
        end else if (!stall_i) begin  // Hold the slot while decode stalls
            pc_o   <= pc_i;
            // Empty fetch slot becomes a harmless addi
            inst_o <= inst_valid_i ? inst_i : `RV_NOP_INST;
        end
    end

endmodule

// File: source/id_decode.sv
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module id_decode
    import rv_id_pkg::*;
(
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_REG_AW-1:0] ex_rd_addr_i,
    input  logic                  ex_rd_we_i,
    input  logic [`RV_XLEN-1:0]   ex_rd_data_i,
    input  alu_op_e               ex_alu_op_i,
    input  logic [`RV_REG_AW-1:0] mem_rd_addr_i,
    input  logic                  mem_rd_we_i,
    input  logic [`RV_XLEN-1:0]   mem_rd_data_i,
    input  logic [`RV_XLEN-1:0]   rs1_data_i,
    input  logic [`RV_XLEN-1:0]   rs2_data_i,
    output logic [`RV_REG_AW-1:0] rs1_addr_o,
    output logic                  rs1_re_o,
    output logic [`RV_REG_AW-1:0] rs2_addr_o,
    output logic                  rs2_re_o,
    output logic [`RV_XLEN-1:0]   reg1_o,
    output logic [`RV_XLEN-1:0]   reg2_o,
    output logic [`RV_XLEN-1:0]   imm_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output logic                  rd_we_o,
    output alu_op_e               alu_op_o,
    output jump_op_e              jump_op_o,
    output branch_op_e            branch_op_o,
    output logic [`RV_XLEN-1:0]   jump_addr_o,
    output logic                  stall_o
);

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic                use_imm;
    logic                illegal;
    logic                ex_is_load;
    logic                rs1_hazard, rs2_hazard;
    logic [`RV_XLEN-1:0] rs1_val, rs2_val;

    assign opcode     = opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        illegal     = 1'b0;
        use_imm     = 1'b0;
        rs1_re_o    = 1'b0;
        rs2_re_o    = 1'b0;
        imm_o       = '0;
        rd_o        = inst_i[11:7];
        rd_we_o     = 1'b0;
        alu_op_o    = ALU_NOP;
        jump_op_o   = JMP_NONE;
        branch_op_o = BR_NONE;
        case (opcode)
            OPC_OP_IMM: begin
                rd_we_o  = 1'b1;
                rs1_re_o = 1'b1;
                use_imm  = 1'b1;
                imm_o    = imm_i;
                case (funct3)
                    3'b000: alu_op_o = ADDI;
                    3'b010: alu_op_o = SLTI;
                    3'b011: alu_op_o = SLTIU;
                    3'b100: alu_op_o = XORI;
                    3'b110: alu_op_o = ORI;
                    3'b111: alu_op_o = ANDI;
                    3'b001: case (funct7)
                        7'h00:   alu_op_o = SLLI;
                        default: illegal  = 1'b1;
                    endcase
                    default: case (funct7)           // 3'b101
                        7'h00:   alu_op_o = SRLI;
                        7'h20:   alu_op_o = SRAI;
                        default: illegal  = 1'b1;
                    endcase
                endcase
            end
            OPC_OP: begin
                rd_we_o  = 1'b1;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op_o = ADD;
                    {7'h20, 3'b000}: alu_op_o = SUB;
                    {7'h00, 3'b001}: alu_op_o = SLL;
                    {7'h00, 3'b010}: alu_op_o = SLT;
                    {7'h00, 3'b011}: alu_op_o = SLTU;
                    {7'h00, 3'b100}: alu_op_o = XOR;
                    {7'h00, 3'b101}: alu_op_o = SRL;
                    {7'h20, 3'b101}: alu_op_o = SRA;
                    {7'h00, 3'b110}: alu_op_o = OR;
                    {7'h00, 3'b111}: alu_op_o = AND;
                    default:         illegal  = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                rd_we_o  = 1'b1;
                rs1_re_o = 1'b1;
                use_imm  = 1'b1;
                imm_o    = imm_i;
                case (funct3)
                    3'b000:  alu_op_o = LB;
                    3'b001:  alu_op_o = LH;
                    3'b010:  alu_op_o = LW;
                    3'b100:  alu_op_o = LBU;
                    3'b101:  alu_op_o = LHU;
                    default: illegal  = 1'b1;
                endcase
            end
            OPC_STORE: begin
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                use_imm  = 1'b1;
                imm_o    = imm_s;
                case (funct3)
                    3'b000:  alu_op_o = SB;
                    3'b001:  alu_op_o = SH;
                    3'b010:  alu_op_o = SW;
                    default: illegal  = 1'b1;
                endcase
            end
            OPC_BRANCH: begin
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                use_imm  = 1'b1;
                imm_o    = imm_b;
                alu_op_o = BRANCH;
                case (funct3)
                    3'b000:  branch_op_o = BEQ;
                    3'b001:  branch_op_o = BNE;
                    3'b100:  branch_op_o = BLT;
                    3'b101:  branch_op_o = BGE;
                    3'b110:  branch_op_o = BLTU;
                    3'b111:  branch_op_o = BGEU;
                    default: illegal     = 1'b1;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                rd_we_o  = 1'b1;
                use_imm  = 1'b1;
                imm_o    = imm_u;
                alu_op_o = (opcode == OPC_LUI) ? LUI : AUIPC;
            end
            OPC_JAL: begin
                rd_we_o   = 1'b1;
                use_imm   = 1'b1;
                imm_o     = imm_j;
                alu_op_o  = JUMP;
                jump_op_o = JMP_JAL;
            end
            OPC_JALR: begin
                rd_we_o   = 1'b1;
                rs1_re_o  = 1'b1;
                use_imm   = 1'b1;
                imm_o     = imm_i;
                alu_op_o  = JUMP;
                jump_op_o = JMP_JALR;
                illegal   = (funct3 != 3'b000);
            end
            default: illegal = 1'b1;
        endcase

        // Anything not recognised leaves as a plain no-op
        if (illegal) begin
            use_imm     = 1'b0;
            rs1_re_o    = 1'b0;
            rs2_re_o    = 1'b0;
            imm_o       = '0;
            rd_we_o     = 1'b0;
            alu_op_o    = ALU_NOP;
            jump_op_o   = JMP_NONE;
            branch_op_o = BR_NONE;
        end
        if (!rd_we_o) begin
            rd_o = '0;
        end
    end

    assign ex_is_load = ex_alu_op_i inside {LB, LH, LW, LBU, LHU};

    assign rs1_hazard = ex_is_load && ex_rd_we_i && rs1_re_o &&
                        (rs1_addr_o != '0) && (ex_rd_addr_i == rs1_addr_o);
    assign rs2_hazard = ex_is_load && ex_rd_we_i && rs2_re_o &&
                        (rs2_addr_o != '0) && (ex_rd_addr_i == rs2_addr_o);
    assign stall_o    = rs1_hazard || rs2_hazard;

    // Execute wins over memory, x0 and unread ports never forward
    function automatic logic [`RV_XLEN-1:0] resolve(
        input logic                  re,
        input logic [`RV_REG_AW-1:0] addr,
        input logic [`RV_XLEN-1:0]   rf_data
    );
        logic live;
        live = re && (addr != '0);
        if (live && ex_rd_we_i && (ex_rd_addr_i == addr)) begin
            return ex_is_load ? '0 : ex_rd_data_i;   // Load data not there yet
        end
        if (live && mem_rd_we_i && (mem_rd_addr_i == addr)) begin
            return mem_rd_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_val = resolve(rs1_re_o, rs1_addr_o, rs1_data_i);
        rs2_val = resolve(rs2_re_o, rs2_addr_o, rs2_data_i);
    end

    always_comb begin
        reg1_o      = rs1_val;
        reg2_o      = rs2_re_o ? rs2_val : (use_imm ? imm_o : '0);
        jump_addr_o = '0;
        if (alu_op_o == AUIPC || jump_op_o == JMP_JAL) begin
            reg1_o = pc_i;
        end
        if (jump_op_o == JMP_JALR) begin
            reg1_o      = pc_i;                       // Link address base
            jump_addr_o = rs1_val;
        end
        if (alu_op_o == BRANCH) begin
            jump_addr_o = pc_i;
        end
    end

    // Only a writing load sitting in execute may hold up decode
    always_comb begin
        assert final (!stall_o ||
                      (ex_rd_we_i && (ex_rd_addr_i != '0) &&
                       (ex_alu_op_i == LB || ex_alu_op_i == LH || ex_alu_op_i == LW ||
                        ex_alu_op_i == LBU || ex_alu_op_i == LHU)))
            else $error("stall raised without a load in execute");
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module reg_file (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  logic [`RV_REG_AW-1:0] waddr_i,
    input  logic [`RV_XLEN-1:0]   wdata_i,
    input  logic [`RV_REG_AW-1:0] raddr1_i,
    input  logic                  re1_i,
    input  logic [`RV_REG_AW-1:0] raddr2_i,
    input  logic                  re2_i,
    output logic [`RV_XLEN-1:0]   rdata1_o,
    output logic [`RV_XLEN-1:0]   rdata2_o
);

    logic [`RV_XLEN-1:0] regs [1:31];   // x0 is not stored
    logic                wr_live;

    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rdata1_o = (!re1_i || raddr1_i == '0) ? '0 :
                      (wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (!re2_i || raddr2_i == '0) ? '0 :
                      (wr_live && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

    a_x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((raddr1_i == '0) |-> (rdata1_o == '0)) and ((raddr2_i == '0) |-> (rdata2_o == '0)))
        else $error("x0 read returned nonzero data");

endmodule

// File: source/id_ex_reg.sv
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module id_ex_reg
    import rv_id_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic [`RV_XLEN-1:0]   reg1_i,
    input  logic [`RV_XLEN-1:0]   reg2_i,
    input  logic [`RV_XLEN-1:0]   imm_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic                  rd_we_i,
    input  alu_op_e               alu_op_i,
    input  jump_op_e              jump_op_i,
    input  branch_op_e            branch_op_i,
    input  logic [`RV_XLEN-1:0]   jump_addr_i,
    output logic [`RV_XLEN-1:0]   reg1_o,
    output logic [`RV_XLEN-1:0]   reg2_o,
    output logic [`RV_XLEN-1:0]   imm_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output logic                  rd_we_o,
    output alu_op_e               alu_op_o,
    output jump_op_e              jump_op_o,
    output branch_op_e            branch_op_o,
    output logic [`RV_XLEN-1:0]   jump_addr_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg1_o      <= '0;
            reg2_o      <= '0;
            imm_o       <= '0;
            rd_o        <= '0;
            rd_we_o     <= 1'b0;
            alu_op_o    <= ALU_NOP;
            jump_op_o   <= JMP_NONE;
            branch_op_o <= BR_NONE;
            jump_addr_o <= '0;
        end else begin
            // Stall turns the slot into a bubble
            reg1_o      <= stall_i ? '0 : reg1_i;
            reg2_o      <= stall_i ? '0 : reg2_i;
            imm_o       <= stall_i ? '0 : imm_i;
            rd_o        <= stall_i ? '0 : rd_i;
            rd_we_o     <= stall_i ? 1'b0 : rd_we_i;
            alu_op_o    <= stall_i ? ALU_NOP : alu_op_i;
            jump_op_o   <= stall_i ? JMP_NONE : jump_op_i;
            branch_op_o <= stall_i ? BR_NONE : branch_op_i;
            jump_addr_o <= stall_i ? '0 : jump_addr_i;
        end
    end

    a_stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> (!rd_we_o && alu_op_o == ALU_NOP))
        else $error("stalled slot reached execute with live control");

endmodule

// File: source/id_stage_top.sv
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module id_stage_top
    import rv_id_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic                  inst_valid_i,
    input  logic [`RV_REG_AW-1:0] ex_rd_addr_i,
    input  logic                  ex_rd_we_i,
    input  logic [`RV_XLEN-1:0]   ex_rd_data_i,
    input  alu_op_e               ex_alu_op_i,
    input  logic [`RV_REG_AW-1:0] mem_rd_addr_i,
    input  logic                  mem_rd_we_i,
    input  logic [`RV_XLEN-1:0]   mem_rd_data_i,
    input  logic [`RV_REG_AW-1:0] wb_addr_i,
    input  logic                  wb_we_i,
    input  logic [`RV_XLEN-1:0]   wb_data_i,
    output logic [`RV_XLEN-1:0]   ex_reg1_o,
    output logic [`RV_XLEN-1:0]   ex_reg2_o,
    output logic [`RV_XLEN-1:0]   ex_imm_o,
    output logic [`RV_REG_AW-1:0] ex_rd_o,
    output logic                  ex_rd_we_o,
    output alu_op_e               ex_alu_op_o,
    output jump_op_e              ex_jump_op_o,
    output branch_op_e            ex_branch_op_o,
    output logic [`RV_XLEN-1:0]   ex_jump_addr_o,
    output logic                  stall_o
);

    logic [`RV_XLEN-1:0]   id_pc, id_inst;
    logic [`RV_REG_AW-1:0] rs1_addr, rs2_addr;
    logic                  rs1_re, rs2_re;
    logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
    logic [`RV_XLEN-1:0]   reg1, reg2, imm, jump_addr;
    logic [`RV_REG_AW-1:0] rd;
    logic                  rd_we;
    alu_op_e               alu_op;
    jump_op_e              jump_op;
    branch_op_e            branch_op;

    if_id_reg u_if_id (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_o),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .pc_o         (id_pc),
        .inst_o       (id_inst)
    );

    id_decode u_id (
        .pc_i          (id_pc),
        .inst_i        (id_inst),
        .ex_rd_addr_i  (ex_rd_addr_i),
        .ex_rd_we_i    (ex_rd_we_i),
        .ex_rd_data_i  (ex_rd_data_i),
        .ex_alu_op_i   (ex_alu_op_i),
        .mem_rd_addr_i (mem_rd_addr_i),
        .mem_rd_we_i   (mem_rd_we_i),
        .mem_rd_data_i (mem_rd_data_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs1_re_o      (rs1_re),
        .rs2_addr_o    (rs2_addr),
        .rs2_re_o      (rs2_re),
        .reg1_o        (reg1),
        .reg2_o        (reg2),
        .imm_o         (imm),
        .rd_o          (rd),
        .rd_we_o       (rd_we),
        .alu_op_o      (alu_op),
        .jump_op_o     (jump_op),
        .branch_op_o   (branch_op),
        .jump_addr_o   (jump_addr),
        .stall_o       (stall_o)
    );

    reg_file u_regs (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (rs1_addr),
        .re1_i    (rs1_re),
        .raddr2_i (rs2_addr),
        .re2_i    (rs2_re),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    id_ex_reg u_id_ex (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_o),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .imm_i       (imm),
        .rd_i        (rd),
        .rd_we_i     (rd_we),
        .alu_op_i    (alu_op),
        .jump_op_i   (jump_op),
        .branch_op_i (branch_op),
        .jump_addr_i (jump_addr),
        .reg1_o      (ex_reg1_o),
        .reg2_o      (ex_reg2_o),
        .imm_o       (ex_imm_o),
        .rd_o        (ex_rd_o),
        .rd_we_o     (ex_rd_we_o),
        .alu_op_o    (ex_alu_op_o),
        .jump_op_o   (ex_jump_op_o),
        .branch_op_o (ex_branch_op_o),
        .jump_addr_o (ex_jump_addr_o)
    );

endmodule

// File: verif/id_stage_vectors.svh
`ifndef ID_STAGE_VECTORS_SVH
`define ID_STAGE_VECTORS_SVH

// Columns: pc, inst, ex rd/we/op, mem rd/we, wb rd/we
//   then expected alu, jump, branch, rd, rd_we, imm, reg1 src, reg2 src, jump_addr src, stall
task automatic load_vectors();
    add_row("add_rf", vec_t'{32'h100, 32'h002081B3, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        ADD, JMP_NONE, BR_NONE, 5'd3, 1'b1, 32'h0, S_RF, S_RF, S_ZERO, 1'b0});
    add_row("sub_ex_mem", vec_t'{32'h104, 32'h406302B3, 5'd6, 1'b1, ADD, 5'd6, 1'b1, 5'd0, 1'b0,
        SUB, JMP_NONE, BR_NONE, 5'd5, 1'b1, 32'h0, S_EX, S_EX, S_ZERO, 1'b0});
    add_row("or_mem", vec_t'{32'h108, 32'h00A4E433, 5'd11, 1'b1, ADD, 5'd10, 1'b1, 5'd0, 1'b0,
        OR, JMP_NONE, BR_NONE, 5'd8, 1'b1, 32'h0, S_RF, S_MEM, S_ZERO, 1'b0});
    add_row("x0_nofwd", vec_t'{32'h10C, 32'h00000233, 5'd0, 1'b1, ADD, 5'd0, 1'b1, 5'd0, 1'b0,
        ADD, JMP_NONE, BR_NONE, 5'd4, 1'b1, 32'h0, S_ZERO, S_ZERO, S_ZERO, 1'b0});
    add_row("and_bypass", vec_t'{32'h110, 32'h00E6F633, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd13, 1'b1,
        AND, JMP_NONE, BR_NONE, 5'd12, 1'b1, 32'h0, S_WB, S_RF, S_ZERO, 1'b0});
    add_row("addi", vec_t'{32'h114, 32'hFFB10093, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        ADDI, JMP_NONE, BR_NONE, 5'd1, 1'b1, 32'hFFFF_FFFB, S_RF, S_IMM, S_ZERO, 1'b0});
    add_row("lw", vec_t'{32'h118, 32'h01052483, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        LW, JMP_NONE, BR_NONE, 5'd9, 1'b1, 32'h10, S_RF, S_IMM, S_ZERO, 1'b0});
    add_row("sw", vec_t'{32'h11C, 32'hFEB62C23, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        SW, JMP_NONE, BR_NONE, 5'd0, 1'b0, 32'hFFFF_FFF8, S_RF, S_RF, S_ZERO, 1'b0});
    add_row("bne", vec_t'{32'h120, 32'hFE2098E3, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        BRANCH, JMP_NONE, BNE, 5'd0, 1'b0, 32'hFFFF_FFF0, S_RF, S_RF, S_PC, 1'b0});
    add_row("lui", vec_t'{32'h124, 32'hABCDE7B7, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        LUI, JMP_NONE, BR_NONE, 5'd15, 1'b1, 32'hABCD_E000, S_ZERO, S_IMM, S_ZERO, 1'b0});
    add_row("auipc", vec_t'{32'h128, 32'h12345817, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        AUIPC, JMP_NONE, BR_NONE, 5'd16, 1'b1, 32'h1234_5000, S_PC, S_IMM, S_ZERO, 1'b0});
    add_row("jal", vec_t'{32'h12C, 32'hFFDFF0EF, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        JUMP, JMP_JAL, BR_NONE, 5'd1, 1'b1, 32'hFFFF_FFFC, S_PC, S_IMM, S_ZERO, 1'b0});
    add_row("jalr_ex", vec_t'{32'h130, 32'h00C302E7, 5'd6, 1'b1, ADD, 5'd0, 1'b0, 5'd0, 1'b0,
        JUMP, JMP_JALR, BR_NONE, 5'd5, 1'b1, 32'hC, S_PC, S_IMM, S_EX, 1'b0});
    add_row("illegal", vec_t'{32'h134, 32'h1234507F, 5'd0, 1'b0, ALU_NOP, 5'd0, 1'b0, 5'd0, 1'b0,
        ALU_NOP, JMP_NONE, BR_NONE, 5'd0, 1'b0, 32'h0, S_ZERO, S_ZERO, S_ZERO, 1'b0});
    // Load in execute feeds rs1, its data later shows up from memory
    add_row("load_use", vec_t'{32'h138, 32'h016A8A33, 5'd21, 1'b1, LW, 5'd21, 1'b1, 5'd0, 1'b0,
        ADD, JMP_NONE, BR_NONE, 5'd20, 1'b1, 32'h0, S_MEM, S_RF, S_ZERO, 1'b1});
endtask

`endif

// File: verif/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb
    import rv_id_pkg::*;
();

    localparam real         PERIOD_NS = 4.0;
    localparam logic [31:0] EX_VAL    = 32'hE0E0_1111;
    localparam logic [31:0] MEM_VAL   = 32'h3E3E_2222;
    localparam logic [31:0] WB_VAL    = 32'hB0B0_3333;

    // Where an expected operand comes from
    typedef enum logic [2:0] {S_ZERO, S_RF, S_EX, S_MEM, S_WB, S_PC, S_IMM} src_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  ex_rd;
        logic        ex_we;
        alu_op_e     ex_op;
        logic [4:0]  mem_rd;
        logic        mem_we;
        logic [4:0]  wb_rd;
        logic        wb_we;
        alu_op_e     alu;
        jump_op_e    jmp;
        branch_op_e  br;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] imm;
        src_e        s1;
        src_e        s2;
        src_e        sj;
        logic        stall;
    } vec_t;

    logic        clk, rst_n;
    logic [31:0] pc, inst;
    logic        inst_valid;
    logic [4:0]  ex_rd_addr, mem_rd_addr, wb_addr;
    logic        ex_rd_we, mem_rd_we, wb_we;
    logic [31:0] ex_rd_data, mem_rd_data, wb_data;
    alu_op_e     ex_alu_op;
    logic [31:0] dec_reg1, dec_reg2, dec_imm, dec_jump_addr;
    logic [4:0]  dec_rd;
    logic        dec_rd_we;
    alu_op_e     dec_alu_op;
    jump_op_e    dec_jump_op;
    branch_op_e  dec_branch_op;
    logic        stall;

    logic [31:0] shadow [0:31];   // Model of the register file contents
    vec_t        rows[$];
    string       names[$];
    int          n_errors, n_tests, n_failed;

    always #2 clk = ~clk;

    id_stage_top u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .pc_i           (pc),
        .inst_i         (inst),
        .inst_valid_i   (inst_valid),
        .ex_rd_addr_i   (ex_rd_addr),
        .ex_rd_we_i     (ex_rd_we),
        .ex_rd_data_i   (ex_rd_data),
        .ex_alu_op_i    (ex_alu_op),
        .mem_rd_addr_i  (mem_rd_addr),
        .mem_rd_we_i    (mem_rd_we),
        .mem_rd_data_i  (mem_rd_data),
        .wb_addr_i      (wb_addr),
        .wb_we_i        (wb_we),
        .wb_data_i      (wb_data),
        .ex_reg1_o      (dec_reg1),
        .ex_reg2_o      (dec_reg2),
        .ex_imm_o       (dec_imm),
        .ex_rd_o        (dec_rd),
        .ex_rd_we_o     (dec_rd_we),
        .ex_alu_op_o    (dec_alu_op),
        .ex_jump_op_o   (dec_jump_op),
        .ex_branch_op_o (dec_branch_op),
        .ex_jump_addr_o (dec_jump_addr),
        .stall_o        (stall)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic stop_on_timeout(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Step n falling edges, complaining if the clock falls behind
    task automatic advance(input int n);
        realtime t0;
        t0 = $realtime;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            if ($realtime - t0 > (k + 1) * PERIOD_NS + 0.1) begin
                stop_on_timeout("clock edge arrived late");
            end
        end
    endtask

    task automatic add_row(input string name, input vec_t v);
        names.push_back(name);
        rows.push_back(v);
    endtask

    `include "id_stage_vectors.svh"

    function automatic logic [31:0] operand(input src_e s, input logic [4:0] rs, input vec_t v);
        case (s)
            S_RF:    return shadow[rs];
            S_EX:    return EX_VAL;
            S_MEM:   return MEM_VAL;
            S_WB:    return WB_VAL;
            S_PC:    return v.pc;
            S_IMM:   return v.imm;
            default: return '0;
        endcase
    endfunction

    task automatic drive_idle();
        ex_rd_addr  = '0;
        ex_rd_we    = 1'b0;
        ex_alu_op   = ALU_NOP;
        mem_rd_addr = '0;
        mem_rd_we   = 1'b0;
        wb_addr     = '0;
        wb_we       = 1'b0;
        wb_data     = WB_VAL;
    endtask

    task automatic check_bubble(input string tag);
        check_value({tag, " bubble reg1"}, dec_reg1, '0);
        check_value({tag, " bubble reg2"}, dec_reg2, '0);
        check_value({tag, " bubble imm"}, dec_imm, '0);
        check_value({tag, " bubble rd"}, dec_rd, '0);
        check_value({tag, " bubble rd_we"}, dec_rd_we, '0);
        check_value({tag, " bubble alu_op"}, dec_alu_op, ALU_NOP);
        check_value({tag, " bubble jump_op"}, dec_jump_op, JMP_NONE);
        check_value({tag, " bubble branch_op"}, dec_branch_op, BR_NONE);
        check_value({tag, " bubble jump_addr"}, dec_jump_addr, '0);
    endtask

    task automatic check_decode(input string tag, input vec_t v);
        check_value({tag, " alu_op"}, dec_alu_op, v.alu);
        check_value({tag, " jump_op"}, dec_jump_op, v.jmp);
        check_value({tag, " branch_op"}, dec_branch_op, v.br);
        check_value({tag, " rd"}, dec_rd, v.rd);
        check_value({tag, " rd_we"}, dec_rd_we, v.rd_we);
        check_value({tag, " imm"}, dec_imm, v.imm);
        check_value({tag, " reg1"}, dec_reg1, operand(v.s1, v.inst[19:15], v));
        check_value({tag, " reg2"}, dec_reg2, operand(v.s2, v.inst[24:20], v));
        check_value({tag, " jump_addr"}, dec_jump_addr, operand(v.sj, v.inst[19:15], v));
    endtask

    task automatic run_row(input int i);
        vec_t  v;
        string tag;
        int    errs0;
        int    polls;
        v     = rows[i];
        tag   = names[i];
        errs0 = n_errors;
        pc         = v.pc;
        inst       = v.inst;
        inst_valid = 1'b1;
        drive_idle();
        advance(1);
        inst_valid  = 1'b0;       // Next fetch slot stays empty
        ex_rd_addr  = v.ex_rd;
        ex_rd_we    = v.ex_we;
        ex_alu_op   = v.ex_op;
        mem_rd_addr = v.mem_rd;
        mem_rd_we   = v.mem_we;
        wb_addr     = v.wb_rd;
        wb_we       = v.wb_we;
        advance(1);
        check_value({tag, " stall"}, stall, v.stall);
        if (v.stall) begin
            check_bubble(tag);
            ex_rd_we  = 1'b0;     // Load has left execute
            ex_alu_op = ALU_NOP;
            wb_we     = 1'b0;
            polls     = 0;
            advance(1);
            while (dec_alu_op === ALU_NOP && polls < 4) begin
                advance(1);
                polls++;
            end
            if (dec_alu_op === ALU_NOP) begin
                stop_on_timeout("held instruction never reached the ID/EX register");
            end
            check_value({tag, " stall after release"}, stall, 1'b0);
        end
        check_decode(tag, v);
        if (v.wb_we && v.wb_rd != '0) begin
            shadow[v.wb_rd] = WB_VAL;
        end
        n_tests++;
        if (n_errors != errs0) begin
            n_failed++;
            $display("test %-12s FAIL", tag);
        end else begin
            $display("test %-12s ok", tag);
        end
    endtask

    initial begin
        #5000;
        stop_on_timeout("simulation ran past its time limit");
    end

    initial begin
        logic [31:0] rnd;
        int          polls;
        clk         = 1'b0;
        rst_n       = 1'b0;
        pc          = '0;
        inst        = '0;
        inst_valid  = 1'b0;
        ex_rd_data  = EX_VAL;
        mem_rd_data = MEM_VAL;
        drive_idle();
        n_errors = 0;
        n_tests  = 0;
        n_failed = 0;
        void'($urandom(40));
        load_vectors();

        advance(2);
        rst_n = 1'b1;
        polls = 0;
        while (!(stall === 1'b0 && dec_alu_op === ALU_NOP) && polls < 5) begin
            advance(1);
            polls++;
        end
        if (!(stall === 1'b0 && dec_alu_op === ALU_NOP)) begin
            stop_on_timeout("DUT outputs never settled after reset");
        end
        check_bubble("reset");
        check_value("reset stall", stall, 1'b0);
        n_tests++;
        if (n_errors != 0) begin
            n_failed++;
        end
        $display("test %-12s %s", "reset", (n_errors != 0) ? "FAIL" : "ok");

        // Fill x1..x31 through write-back
        shadow[0] = '0;
        for (int r = 1; r < 32; r++) begin
            rnd       = $urandom;
            wb_addr   = 5'(r);
            wb_we     = 1'b1;
            wb_data   = rnd;
            shadow[r] = rnd;
            advance(1);
        end
        drive_idle();

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end

        $display("tests: %0d run, %0d failed, mismatches: %0d", n_tests, n_failed, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+source
+incdir+verif
source/rv_id_pkg.sv
source/if_id_reg.sv
source/id_decode.sv
source/reg_file.sv
source/id_ex_reg.sv
source/id_stage_top.sv
verif/id_stage_tb.sv
